// File: dispatch_pkg.sv
// dispatch stage shared types
`default_nettype none

package dispatch_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // isa widths and instruction word
    //////////////////////////////////////////////////////////////////////////////

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // x0, hard-wired zero
    localparam reg_idx_t zero_reg = 5'd0;

    // r-type field view
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef union packed {
        logic [31:0] raw;
        inst_r_t     r;
    } inst_t;

    //////////////////////////////////////////////////////////////////////////////
    // opcode match values
    //////////////////////////////////////////////////////////////////////////////

    // major opcodes, low two bits always 11
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_t;

    localparam logic [6:0] funct7_base = 7'b0000000;
    // sub and sra
    localparam logic [6:0] funct7_alt  = 7'b0100000;
    // m extension
    localparam logic [6:0] funct7_mul  = 7'b0000001;
    // full word, treated as halt
    localparam logic [31:0] wfi_inst   = 32'h1050_0073;

    //////////////////////////////////////////////////////////////////////////////
    // datapath controls
    //////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        opa_is_rs1,
        opa_is_pc,
        opa_is_zero
    } opa_sel_t;

    typedef enum logic [2:0] {
        opb_is_rs2,
        opb_is_i_imm,
        opb_is_s_imm,
        opb_is_b_imm,
        opb_is_u_imm,
        opb_is_j_imm
    } opb_sel_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mul,
        alu_mulh,
        alu_mulhsu,
        alu_mulhu
    } alu_func_t;

    typedef struct packed {
        opa_sel_t  opa_select;
        opb_sel_t  opb_select;
        alu_func_t alu_func;
        logic      has_dest;
        logic      rd_mem;
        logic      wr_mem;
        logic      cond_branch;
        logic      uncond_branch;
        logic      csr_op;
        logic      halt;
        logic      illegal;
    } ctrl_t;

    // add x0, x0, x0 with every flag low
    localparam ctrl_t nop_ctrl = '{
        opa_select: opa_is_rs1,
        opb_select: opb_is_rs2,
        alu_func:   alu_add,
        default:    1'b0
    };

    //////////////////////////////////////////////////////////////////////////////
    // stage packets
    //////////////////////////////////////////////////////////////////////////////

    // instruction buffer entry
    typedef struct packed {
        logic            valid;
        inst_t           inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
    } ib_packet_t;

    // writeback port into the register file
    typedef struct packed {
        logic            en;
        reg_idx_t        idx;
        logic [xlen-1:0] data;
    } wb_write_t;

    typedef struct packed {
        logic            valid;
        inst_t           inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        ctrl_t           ctrl;
        reg_idx_t        dest_reg_idx;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic            mem;
    } rs_packet_t;

    typedef struct packed {
        inst_t           inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        reg_idx_t        dest_reg_idx;
        logic            rd_mem;
        logic            wr_mem;
    } lsq_packet_t;

    typedef struct packed {
        reg_idx_t        dest_reg_idx;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic            is_branch;
    } rob_packet_t;

endpackage

`default_nettype wire

// File: rv32_decoder.sv
// rv32im instruction decoder
`default_nettype none

module rv32_decoder (
    input  dispatch_pkg::inst_t inst,
    input  logic                valid,
    output dispatch_pkg::ctrl_t ctrl
);

    // funct3 to base alu op, alt picks sub / sra
    function automatic dispatch_pkg::alu_func_t base_alu(input logic [2:0] funct3,
                                                        input logic       alt);
        dispatch_pkg::alu_func_t func;
        case (funct3)
            3'b000:  func = alt ? dispatch_pkg::alu_sub : dispatch_pkg::alu_add;
            3'b001:  func = dispatch_pkg::alu_sll;
            3'b010:  func = dispatch_pkg::alu_slt;
            3'b011:  func = dispatch_pkg::alu_sltu;
            3'b100:  func = dispatch_pkg::alu_xor;
            3'b101:  func = alt ? dispatch_pkg::alu_sra : dispatch_pkg::alu_srl;
            3'b110:  func = dispatch_pkg::alu_or;
            default: func = dispatch_pkg::alu_and;
        endcase
        return func;
    endfunction

    // encoding outside the supported subset
    logic bad;

    always_comb begin
        // nop unless something below matches
        ctrl = dispatch_pkg::nop_ctrl;
        bad  = 1'b0;
        if (valid) begin
            case (inst.r.opcode)
                dispatch_pkg::op_lui: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opa_select = dispatch_pkg::opa_is_zero;
                    ctrl.opb_select = dispatch_pkg::opb_is_u_imm;
                end
                dispatch_pkg::op_auipc: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opa_select = dispatch_pkg::opa_is_pc;
                    ctrl.opb_select = dispatch_pkg::opb_is_u_imm;
                end
                dispatch_pkg::op_jal: begin
                    ctrl.has_dest      = 1'b1;
                    ctrl.opa_select    = dispatch_pkg::opa_is_pc;
                    ctrl.opb_select    = dispatch_pkg::opb_is_j_imm;
                    ctrl.uncond_branch = 1'b1;
                end
                dispatch_pkg::op_jalr: begin
                    bad                = inst.r.funct3 != 3'b000;
                    ctrl.has_dest      = 1'b1;
                    ctrl.opb_select    = dispatch_pkg::opb_is_i_imm;
                    ctrl.uncond_branch = 1'b1;
                end
                dispatch_pkg::op_branch: begin
                    // funct3 010 and 011 unassigned
                    bad              = inst.r.funct3[2:1] == 2'b01;
                    ctrl.opa_select  = dispatch_pkg::opa_is_pc;
                    ctrl.opb_select  = dispatch_pkg::opb_is_b_imm;
                    ctrl.cond_branch = 1'b1;
                end
                dispatch_pkg::op_load: begin
                    // lb lh lw lbu lhu only
                    bad             = (inst.r.funct3 == 3'b011) || (inst.r.funct3[2:1] == 2'b11);
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = dispatch_pkg::opb_is_i_imm;
                    ctrl.rd_mem     = 1'b1;
                end
                dispatch_pkg::op_store: begin
                    // sb sh sw only
                    bad             = inst.r.funct3[2] || (inst.r.funct3 == 3'b011);
                    ctrl.opb_select = dispatch_pkg::opb_is_s_imm;
                    ctrl.wr_mem     = 1'b1;
                end
                dispatch_pkg::op_imm: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = dispatch_pkg::opb_is_i_imm;
                    ctrl.alu_func   = base_alu(inst.r.funct3,
                        (inst.r.funct3 == 3'b101) && (inst.r.funct7 == dispatch_pkg::funct7_alt));
                    // shift amounts leave imm[11:5] as a funct7
                    if (inst.r.funct3 == 3'b001) begin
                        bad = inst.r.funct7 != dispatch_pkg::funct7_base;
                    end else if (inst.r.funct3 == 3'b101) begin
                        bad = (inst.r.funct7 != dispatch_pkg::funct7_base)
                           && (inst.r.funct7 != dispatch_pkg::funct7_alt);
                    end
                end
                dispatch_pkg::op_reg: begin
                    ctrl.has_dest = 1'b1;
                    if (inst.r.funct7 == dispatch_pkg::funct7_mul) begin
                        // divides are not handled here
                        bad = inst.r.funct3[2];
                        case (inst.r.funct3[1:0])
                            2'b00:   ctrl.alu_func = dispatch_pkg::alu_mul;
                            2'b01:   ctrl.alu_func = dispatch_pkg::alu_mulh;
                            2'b10:   ctrl.alu_func = dispatch_pkg::alu_mulhsu;
                            default: ctrl.alu_func = dispatch_pkg::alu_mulhu;
                        endcase
                    end else begin
                        ctrl.alu_func = base_alu(inst.r.funct3,
                                                 inst.r.funct7 == dispatch_pkg::funct7_alt);
                        // alt form exists for sub and sra only
                        if (inst.r.funct7 == dispatch_pkg::funct7_alt) begin
                            bad = !(inst.r.funct3 inside {3'b000, 3'b101});
                        end else begin
                            bad = inst.r.funct7 != dispatch_pkg::funct7_base;
                        end
                    end
                end
                dispatch_pkg::op_system: begin
                    if (inst.raw == dispatch_pkg::wfi_inst) begin
                        ctrl.halt = 1'b1;
                    end else if (inst.r.funct3 inside {3'b001, 3'b010, 3'b011}) begin
                        // csrrw csrrs csrrc
                        ctrl.csr_op = 1'b1;
                    end else begin
                        bad = 1'b1;
                    end
                end
                default: begin
                    bad = 1'b1;
                end
            endcase
        end
        // unsupported word goes out as a flagged nop
        if (bad) begin
            ctrl         = dispatch_pkg::nop_ctrl;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: arch_regfile.sv
// architectural register file
`default_nettype none

module arch_regfile (
    input  logic                          clock,
    input  logic                          reset,
    input  dispatch_pkg::reg_idx_t        read_idx_1,
    input  dispatch_pkg::reg_idx_t        read_idx_2,
    input  dispatch_pkg::wb_write_t       write,
    output logic [dispatch_pkg::xlen-1:0] read_data_1,
    output logic [dispatch_pkg::xlen-1:0] read_data_2
);

    // x1..x31, x0 never stored
    logic [dispatch_pkg::xlen-1:0] registers [1:31];

    // both read ports as one indexed pair
    dispatch_pkg::reg_idx_t        rd_idx  [2];
    logic [dispatch_pkg::xlen-1:0] rd_data [2];

    assign rd_idx[0]   = read_idx_1;
    assign rd_idx[1]   = read_idx_2;
    assign read_data_1 = rd_data[0];
    assign read_data_2 = rd_data[1];

    for (genvar p = 0; p < 2; p++) begin : g_read
        always_comb begin
            if (rd_idx[p] == dispatch_pkg::zero_reg) begin
                rd_data[p] = '0;
            end else if (write.en && (write.idx == rd_idx[p])) begin
                // same-cycle writeback bypass
                rd_data[p] = write.data;
            end else begin
                rd_data[p] = registers[rd_idx[p]];
            end
        end
    end

    // single writeback port, x0 writes dropped
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write.en && (write.idx != dispatch_pkg::zero_reg)) begin
            registers[write.idx] <= write.data;
        end
    end

endmodule

`default_nettype wire

// File: rename_map_table.sv
// register to rob tag map table
`default_nettype none

module rename_map_table #(
    parameter int ROB_SIZE = 32
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable,
    input  logic                        squash,
    input  logic                        has_dest,
    input  dispatch_pkg::reg_idx_t      read_idx_1,
    input  dispatch_pkg::reg_idx_t      read_idx_2,
    input  dispatch_pkg::reg_idx_t      dest_reg_idx,
    input  logic [$clog2(ROB_SIZE)-1:0] rob_tail,
    output logic [$clog2(ROB_SIZE)-1:0] tag_1,
    output logic [$clog2(ROB_SIZE)-1:0] tag_2,
    output logic [1:0]                  tag_valid
);

    // one tag and one valid bit per architectural register
    logic [$clog2(ROB_SIZE)-1:0] tags [32];
    logic [31:0]                 valid_bits;

    // asynchronous reads, bit 0 is src1
    assign tag_1     = tags[read_idx_1];
    assign tag_2     = tags[read_idx_2];
    assign tag_valid = {valid_bits[read_idx_2], valid_bits[read_idx_1]};

    // squash beats a same-cycle update
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < 32; i++) begin
                tags[i] <= '0;
            end
            valid_bits <= '0;
        end else if (enable && has_dest) begin
            // x0 gets an entry too
            tags[dest_reg_idx]       <= rob_tail;
            valid_bits[dest_reg_idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: dispatch_stage.sv
// single-issue dispatch stage
`default_nettype none

module dispatch_stage #(
    parameter int ROB_SIZE = 32
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable,
    input  logic                        take_branch,
    input  dispatch_pkg::ib_packet_t    ib_packet,
    input  logic [$clog2(ROB_SIZE)-1:0] rob_tail,
    input  dispatch_pkg::wb_write_t     wb_write,
    output dispatch_pkg::rs_packet_t    rs_packet,
    output dispatch_pkg::lsq_packet_t   lsq_packet,
    output dispatch_pkg::rob_packet_t   rob_packet,
    output logic [$clog2(ROB_SIZE)-1:0] src1_tag,
    output logic [$clog2(ROB_SIZE)-1:0] src2_tag,
    output logic [1:0]                  src_tag_valid
);

    dispatch_pkg::ctrl_t           ctrl;
    dispatch_pkg::reg_idx_t        dest_reg_idx;
    logic [dispatch_pkg::xlen-1:0] rs1_value;
    logic [dispatch_pkg::xlen-1:0] rs2_value;

    //////////////////////////////////////////////////////////////////////////////
    // decode, operand read, rename
    //////////////////////////////////////////////////////////////////////////////

    rv32_decoder u_decoder (
        .inst  (ib_packet.inst),
        .valid (ib_packet.valid),
        .ctrl  (ctrl)
    );

    // no destination maps to x0
    assign dest_reg_idx = ctrl.has_dest ? ib_packet.inst.r.rd : dispatch_pkg::zero_reg;

    arch_regfile u_regfile (
        .clock       (clock),
        .reset       (reset),
        .read_idx_1  (ib_packet.inst.r.rs1),
        .read_idx_2  (ib_packet.inst.r.rs2),
        .write       (wb_write),
        .read_data_1 (rs1_value),
        .read_data_2 (rs2_value)
    );

    // sources looked up before this instruction claims its dest
    rename_map_table #(
        .ROB_SIZE (ROB_SIZE)
    ) u_map_table (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .squash       (take_branch),
        .has_dest     (ctrl.has_dest),
        .read_idx_1   (ib_packet.inst.r.rs1),
        .read_idx_2   (ib_packet.inst.r.rs2),
        .dest_reg_idx (dest_reg_idx),
        .rob_tail     (rob_tail),
        .tag_1        (src1_tag),
        .tag_2        (src2_tag),
        .tag_valid    (src_tag_valid)
    );

    //////////////////////////////////////////////////////////////////////////////
    // output packets
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // illegal words never reach the rs
        rs_packet.valid        = ib_packet.valid && !ctrl.illegal;
        rs_packet.inst         = ib_packet.inst;
        rs_packet.pc           = ib_packet.pc;
        rs_packet.npc          = ib_packet.npc;
        rs_packet.ctrl         = ctrl;
        rs_packet.dest_reg_idx = dest_reg_idx;
        rs_packet.rs1_value    = rs1_value;
        rs_packet.rs2_value    = rs2_value;
        rs_packet.mem          = ctrl.rd_mem || ctrl.wr_mem;

        // lsq copy
        lsq_packet.inst         = rs_packet.inst;
        lsq_packet.pc           = rs_packet.pc;
        lsq_packet.npc          = rs_packet.npc;
        lsq_packet.dest_reg_idx = rs_packet.dest_reg_idx;
        lsq_packet.rd_mem       = ctrl.rd_mem;
        lsq_packet.wr_mem       = ctrl.wr_mem;

        // rob copy, jumps count as branches
        rob_packet.dest_reg_idx = rs_packet.dest_reg_idx;
        rob_packet.pc           = rs_packet.pc;
        rob_packet.npc          = rs_packet.npc;
        rob_packet.is_branch    = ctrl.cond_branch || ctrl.uncond_branch;
    end

endmodule

`default_nettype wire

// File: dispatch_sva.sv
// dispatch stage assertions
`default_nettype none

module dispatch_sva (
    input logic                      clock,
    input logic                      reset,
    input logic                      take_branch,
    input dispatch_pkg::rs_packet_t  rs_packet,
    input dispatch_pkg::lsq_packet_t lsq_packet,
    input dispatch_pkg::rob_packet_t rob_packet,
    input logic [1:0]                src_tag_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertion count
    int fail_count = 0;

    // flagged words never issue
    a_illegal_not_valid: assert property (@(posedge clock) disable iff (reset)
        rs_packet.ctrl.illegal |-> !rs_packet.valid)
    else begin
        fail_count++;
        $error("illegal instruction marked valid");
    end

    // lsq and rob packets mirror the rs fields
    a_packet_copies: assert property (@(posedge clock) disable iff (reset)
        (lsq_packet.inst == rs_packet.inst) && (lsq_packet.pc == rs_packet.pc)
        && (lsq_packet.npc == rs_packet.npc)
        && (lsq_packet.dest_reg_idx == rs_packet.dest_reg_idx)
        && (lsq_packet.rd_mem == rs_packet.ctrl.rd_mem)
        && (lsq_packet.wr_mem == rs_packet.ctrl.wr_mem)
        && (rob_packet.pc == rs_packet.pc) && (rob_packet.npc == rs_packet.npc)
        && (rob_packet.dest_reg_idx == rs_packet.dest_reg_idx))
    else begin
        fail_count++;
        $error("lsq or rob packet differs from rs packet");
    end

    a_is_branch: assert property (@(posedge clock) disable iff (reset)
        rob_packet.is_branch == (rs_packet.ctrl.cond_branch || rs_packet.ctrl.uncond_branch))
    else begin
        fail_count++;
        $error("rob is_branch does not match branch flags");
    end

    // whole map cleared by the squash edge
    a_squash_clears: assert property (@(posedge clock) disable iff (reset)
        take_branch |=> (src_tag_valid == 2'b00))
    else begin
        fail_count++;
        $error("source tag valid set after squash");
    end

endmodule

bind dispatch_stage dispatch_sva sva0 (
    .clock         (clock),
    .reset         (reset),
    .take_branch   (take_branch),
    .rs_packet     (rs_packet),
    .lsq_packet    (lsq_packet),
    .rob_packet    (rob_packet),
    .src_tag_valid (src_tag_valid)
);

`default_nettype wire

// File: dispatch_tb.sv
// dispatch stage testbench
`default_nettype none

module dispatch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int rob_size   = 32;
    localparam int tag_w      = $clog2(rob_size);
    // 10 reset cycles, about 400 test cycles, margin
    localparam int max_cycles = 600;

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      enable;
    logic                      take_branch;
    dispatch_pkg::ib_packet_t  ib_packet;
    logic [tag_w-1:0]          rob_tail;
    dispatch_pkg::wb_write_t   wb_write;
    dispatch_pkg::rs_packet_t  rs_packet;
    dispatch_pkg::lsq_packet_t lsq_packet;
    dispatch_pkg::rob_packet_t rob_packet;
    logic [tag_w-1:0]          src1_tag;
    logic [tag_w-1:0]          src2_tag;
    logic [1:0]                src_tag_valid;

    // reference state
    logic [31:0]         model_regs [32];
    logic [tag_w-1:0]    model_tags [32];
    logic [31:0]         model_valid;
    // controls expected for the word on ib_packet
    dispatch_pkg::ctrl_t exp_ctrl;
    integer              seed   = 32'h2ae4ce21;
    int                  cycles = 0;

    dispatch_stage #(
        .ROB_SIZE (rob_size)
    ) dut0 (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .take_branch   (take_branch),
        .ib_packet     (ib_packet),
        .rob_tail      (rob_tail),
        .wb_write      (wb_write),
        .rs_packet     (rs_packet),
        .lsq_packet    (lsq_packet),
        .rob_packet    (rob_packet),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .src_tag_valid (src_tag_valid)
    );

    always #4 clock = ~clock;

    // flags: has_dest rd_mem wr_mem cond uncond csr halt illegal
    function automatic dispatch_pkg::ctrl_t ctrl_word(
        input dispatch_pkg::opa_sel_t  a,
        input dispatch_pkg::opb_sel_t  b,
        input logic [7:0]              flags,
        input dispatch_pkg::alu_func_t f = dispatch_pkg::alu_add
    );
        return {a, b, f, flags};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    // x0 reads zero, same-cycle writeback wins over stored value
    function automatic logic [31:0] model_read(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0
             : (wb_write.en && (wb_write.idx == idx)) ? wb_write.data : model_regs[idx];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error %s expected %h actual %h", name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch");
    endtask

    // one dispatch slot, set up at the falling edge
    task automatic drive_cycle(input logic [31:0] word, input logic valid, input logic en,
                               input logic squash, input dispatch_pkg::ctrl_t expected);
        @(negedge clock);
        ib_packet.valid    = valid;
        ib_packet.inst.raw = word;
        ib_packet.pc       = $random(seed) & ~32'h3;
        ib_packet.npc      = ib_packet.pc + 32'd4;
        enable             = en;
        take_branch        = squash;
        rob_tail           = tag_w'($random(seed));
        wb_write           = '0;
        exp_ctrl           = expected;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks at the rising edge, then model update
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] exp_dest;
        logic       exp_valid;
        if (!reset) begin
            rs1       = ib_packet.inst.raw[19:15];
            rs2       = ib_packet.inst.raw[24:20];
            exp_dest  = exp_ctrl.has_dest ? ib_packet.inst.raw[11:7] : 5'd0;
            exp_valid = ib_packet.valid && !exp_ctrl.illegal;
            assert (rs_packet.rs1_value == model_read(rs1))
            else report_mismatch("rs1_value", model_read(rs1), rs_packet.rs1_value);
            assert (rs_packet.rs2_value == model_read(rs2))
            else report_mismatch("rs2_value", model_read(rs2), rs_packet.rs2_value);
            assert (src_tag_valid == {model_valid[rs2], model_valid[rs1]})
            else report_mismatch("src_tag_valid", 32'({model_valid[rs2], model_valid[rs1]}),
                                 32'(src_tag_valid));
            // tags only matter while valid
            assert (!model_valid[rs1] || (src1_tag == model_tags[rs1]))
            else report_mismatch("src1_tag", 32'(model_tags[rs1]), 32'(src1_tag));
            assert (!model_valid[rs2] || (src2_tag == model_tags[rs2]))
            else report_mismatch("src2_tag", 32'(model_tags[rs2]), 32'(src2_tag));
            assert (rs_packet.ctrl == exp_ctrl)
            else report_mismatch("rs_packet.ctrl", 32'(exp_ctrl), 32'(rs_packet.ctrl));
            assert (rs_packet.dest_reg_idx == exp_dest)
            else report_mismatch("dest_reg_idx", 32'(exp_dest), 32'(rs_packet.dest_reg_idx));
            assert (rs_packet.mem == (exp_ctrl.rd_mem || exp_ctrl.wr_mem))
            else report_mismatch("rs_packet.mem", 32'(exp_ctrl.rd_mem || exp_ctrl.wr_mem),
                                 32'(rs_packet.mem));
            assert (rs_packet.valid == exp_valid)
            else report_mismatch("rs_packet.valid", 32'(exp_valid), 32'(rs_packet.valid));
            // instruction word and pcs pass straight through
            assert (rs_packet.inst.raw == ib_packet.inst.raw)
            else report_mismatch("rs_packet.inst", ib_packet.inst.raw, rs_packet.inst.raw);
            assert (rs_packet.pc == ib_packet.pc)
            else report_mismatch("rs_packet.pc", ib_packet.pc, rs_packet.pc);
            assert (rs_packet.npc == ib_packet.npc)
            else report_mismatch("rs_packet.npc", ib_packet.npc, rs_packet.npc);

            if (wb_write.en && (wb_write.idx != 5'd0)) begin
                model_regs[wb_write.idx] = wb_write.data;
            end
            // squash beats the update, x0 gets a tag like any other
            if (take_branch) begin
                model_valid = '0;
            end else if (enable && exp_ctrl.has_dest) begin
                model_tags[exp_dest]  = rob_tail;
                model_valid[exp_dest] = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("the run hit the cycle limit before the tests finished");
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        dispatch_pkg::ctrl_t nop;
        dispatch_pkg::ctrl_t add_c;
        logic [4:0]          r1;
        logic [4:0]          r2;
        logic [4:0]          rd;
        nop   = ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h00);
        add_c = ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h80);
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
            model_tags[i] = '0;
        end
        model_valid = '0;
        reset       = 1'b1;
        enable      = 1'b0;
        take_branch = 1'b0;
        ib_packet   = '0;
        rob_tail    = '0;
        wb_write    = '0;
        exp_ctrl    = nop;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // writeback traffic under register reads, every fourth write hits rs1
        for (int i = 0; i < 200; i++) begin
            r1 = 5'($random(seed));
            r2 = 5'($random(seed));
            rd = 5'($random(seed));
            drive_cycle(add_word(rd, r1, r2), 1'b1, 1'b0, 1'b0, add_c);
            wb_write.en   = 1'($random(seed));
            wb_write.idx  = ((i % 4) == 0) ? r1 : 5'($random(seed));
            wb_write.data = $random(seed);
        end
        // directed bypass on both ports
        drive_cycle(add_word(5'd1, 5'd9, 5'd9), 1'b1, 1'b0, 1'b0, add_c);
        wb_write = '{en: 1'b1, idx: 5'd9, data: 32'hdead_beef};

        // one word per decoder class, dispatched
        drive_cycle({20'h12345, 5'd12, 7'b0110111}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_zero, dispatch_pkg::opb_is_u_imm, 8'h80));
        drive_cycle({20'h00001, 5'd13, 7'b0010111}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_pc, dispatch_pkg::opb_is_u_imm, 8'h80));
        drive_cycle({20'h00100, 5'd1, 7'b1101111}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_pc, dispatch_pkg::opb_is_j_imm, 8'h88));
        drive_cycle({12'h010, 5'd12, 3'b000, 5'd2, 7'b1100111}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_i_imm, 8'h88));
        drive_cycle({7'b0, 5'd13, 5'd12, 3'b001, 5'b01000, 7'b1100011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_pc, dispatch_pkg::opb_is_b_imm, 8'h10));
        drive_cycle({12'h020, 5'd1, 3'b010, 5'd14, 7'b0000011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_i_imm, 8'hc0));
        drive_cycle({7'b0, 5'd14, 5'd2, 3'b010, 5'b00100, 7'b0100011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_s_imm, 8'h20));
        drive_cycle({7'b0100000, 5'd3, 5'd14, 3'b101, 5'd15, 7'b0010011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_i_imm, 8'h80,
                              dispatch_pkg::alu_sra));
        drive_cycle({7'b0100000, 5'd15, 5'd12, 3'b000, 5'd16, 7'b0110011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h80,
                              dispatch_pkg::alu_sub));
        drive_cycle({7'b0000001, 5'd16, 5'd13, 3'b011, 5'd17, 7'b0110011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h80,
                              dispatch_pkg::alu_mulhu));
        drive_cycle({12'h300, 5'd17, 3'b010, 5'd18, 7'b1110011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h04));
        drive_cycle(32'h1050_0073, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h02));
        // custom-0 opcode, then a good word with ib valid low
        drive_cycle({25'h0, 7'b0001011}, 1'b1, 1'b1, 1'b0,
                    ctrl_word(dispatch_pkg::opa_is_rs1, dispatch_pkg::opb_is_rs2, 8'h01));
        drive_cycle(add_word(5'd20, 5'd12, 5'd13), 1'b0, 1'b1, 1'b0, nop);

        // rename x10 to tag 17, disabled write must not move it
        drive_cycle(add_word(5'd10, 5'd1, 5'd2), 1'b1, 1'b1, 1'b0, add_c);
        rob_tail = tag_w'(17);
        drive_cycle(add_word(5'd10, 5'd10, 5'd10), 1'b1, 1'b0, 1'b0, add_c);
        drive_cycle(add_word(5'd11, 5'd10, 5'd0), 1'b1, 1'b0, 1'b0, add_c);
        // squash with an update requested in the same cycle
        drive_cycle(add_word(5'd10, 5'd10, 5'd11), 1'b1, 1'b1, 1'b1, add_c);
        drive_cycle(add_word(5'd11, 5'd10, 5'd11), 1'b1, 1'b0, 1'b0, add_c);

        // mixed dispatch, squash and writeback
        for (int i = 0; i < 180; i++) begin
            r1 = 5'($random(seed));
            r2 = 5'($random(seed));
            rd = 5'($random(seed));
            drive_cycle(add_word(rd, r1, r2), 1'b1, 1'($random(seed)),
                        (5'($random(seed)) == 5'd0), add_c);
            wb_write.en   = 1'($random(seed));
            wb_write.idx  = 5'($random(seed));
            wb_write.data = $random(seed);
        end

        @(negedge clock);
        if (dut0.sva0.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "concurrent assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: dispatch.f
dispatch_pkg.sv
rv32_decoder.sv
arch_regfile.sv
rename_map_table.sv
dispatch_stage.sv
dispatch_sva.sv
dispatch_tb.sv

// File: Bender.yml
package:
  name: dispatch

sources:
  - files:
      - dispatch_pkg.sv
      - rv32_decoder.sv
      - arch_regfile.sv
      - rename_map_table.sv
      - dispatch_stage.sv
  - target: test
    files:
      - dispatch_sva.sv
      - dispatch_tb.sv
